/* build.f */
rtl/mem_pkg.sv
rtl/mem_ifs.sv
rtl/dcache_data.sv
rtl/store_buffer.sv
rtl/mem_stage.sv
rtl/mem_subsys_top.sv
testbench/mem_subsys_tb.sv

/* rtl/dcache_data.sv */
`timescale 1ns/1ns

module dcache_data (
    input logic     clk_i,
    input logic     reset_i,
    dcache_if.array cache
);

    import mem_pkg::*;

    logic [LINE_WORDS-1:0][WORD_SIZE-1:0] lines [NUM_LINES];
    logic [NUM_LINES-1:0]                 dirty;

    assign cache.rd_data = lines[cache.rd_index][cache.rd_word];

    // Fill replaces the line, a drain only touches its masked bytes
    always_ff @(posedge clk_i) begin
        if (cache.fill_en) begin
            lines[cache.fill_index] <= cache.fill_line;
        end else if (cache.wr_en) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (cache.wr_mask[b]) begin
                    lines[cache.wr_index][cache.wr_word][b*8 +: 8] <=
                        cache.wr_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dirty <= '0;
        end else if (cache.fill_en) begin
            dirty[cache.fill_index] <= 1'b0;
        end else if (cache.wr_en) begin
            dirty[cache.wr_index] <= 1'b1;
        end
    end

    // Old contents sampled before the fill lands
    always_ff @(posedge clk_i) begin
        if (cache.fill_en) begin
            cache.evict_line <= lines[cache.fill_index];
        end
    end

    // Pulses only when a dirty line gets replaced
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cache.evict_valid <= 1'b0;
        end else begin
            cache.evict_valid <= cache.fill_en && dirty[cache.fill_index];
        end
    end

    a_no_write_during_fill: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(cache.wr_en && cache.fill_en)
    ) else $error("Drain write and line fill in the same cycle");

endmodule

/* rtl/mem_ifs.sv */
`timescale 1ns/1ns

interface dcache_if;
    import mem_pkg::*;

    // Load read port
    logic [INDEX_SIZE-1:0]    rd_index;
    logic [WORD_OFF_SIZE-1:0] rd_word;
    logic [WORD_SIZE-1:0]     rd_data;

    // Masked word write from a drain
    logic                     wr_en;
    logic [INDEX_SIZE-1:0]    wr_index;
    logic [WORD_OFF_SIZE-1:0] wr_word;
    logic [WORD_SIZE-1:0]     wr_data;
    logic [WORD_BYTES-1:0]    wr_mask;

    // Line refill and dirty eviction
    logic                     fill_en;
    logic [INDEX_SIZE-1:0]    fill_index;
    logic [LINE_SIZE-1:0]     fill_line;
    logic                     evict_valid;
    logic [LINE_SIZE-1:0]     evict_line;

    modport stage (
        output rd_index, rd_word, wr_en, wr_index, wr_word, wr_data, wr_mask,
        output fill_en, fill_index, fill_line,
        input  rd_data, evict_valid, evict_line
    );

    modport array (
        input  rd_index, rd_word, wr_en, wr_index, wr_word, wr_data, wr_mask,
        input  fill_en, fill_index, fill_line,
        output rd_data, evict_valid, evict_line
    );

endinterface

interface sb_if;
    import mem_pkg::*;

    logic [ADDR_SIZE-1:0]  lookup_addr;
    logic [WORD_BYTES-1:0] hit_mask;
    logic [WORD_SIZE-1:0]  hit_data;

    // Oldest entry, removed when drain is high
    logic                  drain;
    logic                  head_valid;
    logic [ADDR_SIZE-1:0]  head_addr;
    logic [WORD_SIZE-1:0]  head_data;
    logic [WORD_BYTES-1:0] head_mask;

    modport stage (
        output lookup_addr, drain,
        input  hit_mask, hit_data, head_valid, head_addr, head_data, head_mask
    );

    modport buffer (
        input  lookup_addr, drain,
        output hit_mask, hit_data, head_valid, head_addr, head_data, head_mask
    );

endinterface

/* rtl/mem_pkg.sv */
package mem_pkg;

    // Address and data widths
    localparam int ADDR_SIZE  = 32;
    localparam int WORD_SIZE  = 32;
    localparam int WORD_BYTES = WORD_SIZE / 8;

    // Cache geometry, direct-mapped
    localparam int LINE_WORDS = 4;
    localparam int LINE_SIZE  = LINE_WORDS * WORD_SIZE;
    localparam int NUM_LINES  = 16;
    localparam int INDEX_SIZE = 4;

    // Address fields: byte 1:0, word 3:2, index 7:4
    localparam int BYTE_OFF_SIZE = 2;
    localparam int WORD_OFF_SIZE = 2;
    localparam int WORD_LSB      = BYTE_OFF_SIZE;
    localparam int INDEX_LSB     = BYTE_OFF_SIZE + WORD_OFF_SIZE;

    localparam int REG_SIZE = 5;
    localparam int ID_SIZE  = 4;

    // Store buffer
    localparam int SB_DEPTH    = 4;
    localparam int SB_PTR_SIZE = 2;
    localparam int WADDR_SIZE  = ADDR_SIZE - BYTE_OFF_SIZE;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_size_e;

endpackage

/* rtl/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           kill_i,
    input  logic                           load_i,
    input  logic                           fill_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0]  addr_i,
    input  mem_pkg::memop_size_e           size_i,
    input  logic                           sign_ext_i,
    input  logic [mem_pkg::REG_SIZE-1:0]   rf_waddr_i,
    input  logic [mem_pkg::ID_SIZE-1:0]    instr_id_i,
    input  logic [mem_pkg::INDEX_SIZE-1:0] fill_index_i,
    input  logic [mem_pkg::LINE_SIZE-1:0]  fill_line_i,
    sb_if.stage                            sb,
    dcache_if                              cache,
    output logic [mem_pkg::WORD_SIZE-1:0]  load_data_o,
    output logic                           rf_we_o,
    output logic [mem_pkg::REG_SIZE-1:0]   rf_waddr_o,
    output logic [mem_pkg::ID_SIZE-1:0]    instr_id_o
);

    import mem_pkg::*;

    logic [WORD_SIZE-1:0] merged;
    logic [WORD_SIZE-1:0] shifted;
    logic [WORD_SIZE-1:0] extended;

    dcache_data u_dcache_data (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .cache   (cache.array)
    );

    // Same address to the array and the buffer lookup
    assign cache.rd_index = addr_i[INDEX_LSB +: INDEX_SIZE];
    assign cache.rd_word  = addr_i[WORD_LSB +: WORD_OFF_SIZE];
    assign sb.lookup_addr = addr_i;

    // Write port is free when no load or fill needs the array
    assign sb.drain       = sb.head_valid && !load_i && !fill_i;
    assign cache.wr_en    = sb.drain;
    assign cache.wr_index = sb.head_addr[INDEX_LSB +: INDEX_SIZE];
    assign cache.wr_word  = sb.head_addr[WORD_LSB +: WORD_OFF_SIZE];
    assign cache.wr_data  = sb.head_data;
    assign cache.wr_mask  = sb.head_mask;

    assign cache.fill_en    = fill_i;
    assign cache.fill_index = fill_index_i;
    assign cache.fill_line  = fill_line_i;

    // Pending store bytes are newer than the array
    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            merged[b*8 +: 8] = sb.hit_mask[b] ? sb.hit_data[b*8 +: 8]
                                              : cache.rd_data[b*8 +: 8];
        end
    end

    assign shifted = merged >> {addr_i[BYTE_OFF_SIZE-1:0], 3'b000};

    always_comb begin
        case (size_i)
            BYTE:    extended = {{(WORD_SIZE-8){sign_ext_i & shifted[7]}}, shifted[7:0]};
            HALF:    extended = {{(WORD_SIZE-16){sign_ext_i & shifted[15]}}, shifted[15:0]};
            default: extended = shifted;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rf_we_o <= 1'b0;
        end else begin
            rf_we_o <= load_i && !kill_i;
        end
    end

    always_ff @(posedge clk_i) begin
        load_data_o <= extended;
        rf_waddr_o  <= rf_waddr_i;
        instr_id_o  <= instr_id_i;
    end

    a_load_fill_apart: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(load_i && fill_i)
    ) else $error("Load and line fill in the same cycle");

    a_load_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        load_i |-> (size_i == BYTE) || (size_i == HALF && !addr_i[0]) ||
                   (addr_i[BYTE_OFF_SIZE-1:0] == '0)
    ) else $error("Misaligned load");

endmodule

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           kill_i,
    input  logic                           load_i,
    input  logic                           store_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0]  addr_i,
    input  mem_pkg::memop_size_e           size_i,
    input  logic                           sign_ext_i,
    input  logic [mem_pkg::WORD_SIZE-1:0]  store_data_i,
    input  logic [mem_pkg::REG_SIZE-1:0]   rf_waddr_i,
    input  logic [mem_pkg::ID_SIZE-1:0]    instr_id_i,
    input  logic                           fill_i,
    input  logic [mem_pkg::INDEX_SIZE-1:0] fill_index_i,
    input  logic [mem_pkg::LINE_SIZE-1:0]  fill_line_i,
    output logic [mem_pkg::WORD_SIZE-1:0]  load_data_o,
    output logic                           rf_we_o,
    output logic [mem_pkg::REG_SIZE-1:0]   rf_waddr_o,
    output logic [mem_pkg::ID_SIZE-1:0]    instr_id_o,
    output logic                           sb_full_o,
    output logic                           sb_empty_o,
    output logic                           evict_valid_o,
    output logic [mem_pkg::LINE_SIZE-1:0]  evict_line_o
);

    dcache_if cache_bus ();
    sb_if     sb_bus ();

    store_buffer u_store_buffer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .store_i      (store_i),
        .addr_i       (addr_i),
        .size_i       (size_i),
        .store_data_i (store_data_i),
        .sb           (sb_bus.buffer),
        .full_o       (sb_full_o),
        .empty_o      (sb_empty_o)
    );

    mem_stage u_mem_stage (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .kill_i       (kill_i),
        .load_i       (load_i),
        .fill_i       (fill_i),
        .addr_i       (addr_i),
        .size_i       (size_i),
        .sign_ext_i   (sign_ext_i),
        .rf_waddr_i   (rf_waddr_i),
        .instr_id_i   (instr_id_i),
        .fill_index_i (fill_index_i),
        .fill_line_i  (fill_line_i),
        .sb           (sb_bus.stage),
        .cache        (cache_bus),
        .load_data_o  (load_data_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .instr_id_o   (instr_id_o)
    );

    // Eviction goes straight out to the refiller
    assign evict_valid_o = cache_bus.evict_valid;
    assign evict_line_o  = cache_bus.evict_line;

endmodule

/* rtl/store_buffer.sv */
`timescale 1ns/1ns

module store_buffer (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          store_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0] addr_i,
    input  mem_pkg::memop_size_e          size_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] store_data_i,
    sb_if.buffer                          sb,
    output logic                          full_o,
    output logic                          empty_o
);

    import mem_pkg::*;

    logic [SB_DEPTH-1:0]      valid;
    logic [WADDR_SIZE-1:0]    waddr [SB_DEPTH];
    logic [WORD_SIZE-1:0]     data  [SB_DEPTH];
    logic [WORD_BYTES-1:0]    mask  [SB_DEPTH];
    logic [SB_PTR_SIZE-1:0]   head;
    logic [SB_PTR_SIZE-1:0]   tail;

    logic [BYTE_OFF_SIZE-1:0] st_off;
    logic [WADDR_SIZE-1:0]    st_waddr;
    logic [WORD_SIZE-1:0]     st_data;
    logic [WORD_BYTES-1:0]    st_mask;
    logic [SB_DEPTH-1:0]      st_match;
    logic [SB_DEPTH-1:0]      merge_sel;
    logic                     alloc;
    logic [WADDR_SIZE-1:0]    lookup_waddr;

    assign st_off   = addr_i[BYTE_OFF_SIZE-1:0];
    assign st_waddr = addr_i[ADDR_SIZE-1:BYTE_OFF_SIZE];

    // Data replicated over all lanes
    always_comb begin
        case (size_i)
            BYTE: begin
                st_data = {WORD_BYTES{store_data_i[7:0]}};
                st_mask = WORD_BYTES'(1) << st_off;
            end
            HALF: begin
                st_data = {2{store_data_i[15:0]}};
                st_mask = WORD_BYTES'(3) << st_off;
            end
            default: begin
                st_data = store_data_i;
                st_mask = '1;
            end
        endcase
    end

    // A head that drains this cycle cannot take the merge
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            st_match[i]  = valid[i] && (waddr[i] == st_waddr);
            merge_sel[i] = store_i && st_match[i] &&
                           !(sb.drain && (SB_PTR_SIZE'(i) == head));
        end
    end

    assign alloc = store_i && (merge_sel == '0);

    // At most one entry per word can match
    assign lookup_waddr = sb.lookup_addr[ADDR_SIZE-1:BYTE_OFF_SIZE];

    always_comb begin
        sb.hit_mask = '0;
        sb.hit_data = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid[i] && (waddr[i] == lookup_waddr)) begin
                sb.hit_mask = sb.hit_mask | mask[i];
                sb.hit_data = sb.hit_data | data[i];
            end
        end
    end

    assign sb.head_valid = valid[head];
    assign sb.head_addr  = {waddr[head], {BYTE_OFF_SIZE{1'b0}}};
    assign sb.head_data  = data[head];
    assign sb.head_mask  = mask[head];

    assign full_o  = &valid;
    assign empty_o = ~|valid;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (sb.drain) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (alloc) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (merge_sel[i]) begin
                mask[i] <= mask[i] | st_mask;
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (st_mask[b]) begin
                        data[i][b*8 +: 8] <= st_data[b*8 +: 8];
                    end
                end
            end
        end
        if (alloc) begin
            waddr[tail] <= st_waddr;
            data[tail]  <= st_data;
            mask[tail]  <= st_mask;
        end
    end

    a_no_store_when_full: assert property (
        @(posedge clk_i) disable iff (reset_i)
        store_i |-> !full_o
    ) else $error("Store while the store buffer is full");

    a_store_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        store_i |-> (size_i == BYTE) || (size_i == HALF && !addr_i[0]) ||
                    (addr_i[BYTE_OFF_SIZE-1:0] == '0)
    ) else $error("Misaligned store");

endmodule

/* testbench/mem_subsys_tb.sv */
`timescale 1ns/1ns

module mem_subsys_tb;

    import mem_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int DRAIN_LIMIT = 20;

    // Cycles each test needs, reset included
    localparam int RESET_CYCLES   = 11;
    localparam int FILL_CYCLES    = 129;
    localparam int FWD_CYCLES     = 37;
    localparam int DRAIN_CYCLES   = 22;
    localparam int KILL_CYCLES    = 3;
    localparam int FULL_CYCLES    = 14;
    localparam int TEST_CYCLES    = RESET_CYCLES + FILL_CYCLES + FWD_CYCLES +
                                    DRAIN_CYCLES + KILL_CYCLES + FULL_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic                  clk_i;
    logic                  reset_i;
    logic                  kill_i;
    logic                  load_i;
    logic                  store_i;
    logic [ADDR_SIZE-1:0]  addr_i;
    memop_size_e           size_i;
    logic                  sign_ext_i;
    logic [WORD_SIZE-1:0]  store_data_i;
    logic [REG_SIZE-1:0]   rf_waddr_i;
    logic [ID_SIZE-1:0]    instr_id_i;
    logic                  fill_i;
    logic [INDEX_SIZE-1:0] fill_index_i;
    logic [LINE_SIZE-1:0]  fill_line_i;
    logic [WORD_SIZE-1:0]  load_data_o;
    logic                  rf_we_o;
    logic [REG_SIZE-1:0]   rf_waddr_o;
    logic [ID_SIZE-1:0]    instr_id_o;
    logic                  sb_full_o;
    logic                  sb_empty_o;
    logic                  evict_valid_o;
    logic [LINE_SIZE-1:0]  evict_line_o;

    // Reference model, byte addressed over the 8 used address bits
    logic [7:0]            cmem       [256];
    logic                  dirty_m    [NUM_LINES];
    logic                  pend_valid [256];
    logic [7:0]            pend_byte  [256];

    logic                  exp_load_valid;
    logic [WORD_SIZE-1:0]  exp_data;
    logic [REG_SIZE-1:0]   exp_waddr;
    logic [ID_SIZE-1:0]    exp_id;
    logic                  exp_evict;
    logic [LINE_SIZE-1:0]  exp_line;

    logic [31:0]           rng_state;
    int                    errors;
    int                    checks;

    mem_subsys_top UUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] rand_word();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [7:0] align_addr(input logic [7:0] a, input memop_size_e sz);
        case (sz)
            BYTE:    return a;
            HALF:    return {a[7:1], 1'b0};
            default: return {a[7:2], 2'b00};
        endcase
    endfunction

    function automatic int size_bytes(input memop_size_e sz);
        case (sz)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // Pending store bytes are newer than the cache
    function automatic logic [7:0] view_byte(input logic [7:0] a);
        return pend_valid[a] ? pend_byte[a] : cmem[a];
    endfunction

    function automatic logic [31:0] expect_load(input logic [7:0] a, input memop_size_e sz,
                                                input logic sx);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = view_byte(a);
        b1 = view_byte(a + 8'd1);
        b2 = view_byte(a + 8'd2);
        b3 = view_byte(a + 8'd3);
        case (sz)
            BYTE:    return {{24{sx & b0[7]}}, b0};
            HALF:    return {{16{sx & b1[7]}}, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // One clock, then check what the previous cycle produced and go idle
    task automatic step();
        logic we_next;
        we_next = load_i && !kill_i;
        @(posedge clk_i);
        #DRIVE_DELAY;
        check_value("rf_we_o", rf_we_o, we_next);
        check_value("evict_valid_o", evict_valid_o, exp_evict);
        if (exp_evict) begin
            check_value("evict_line_o", evict_line_o, exp_line);
        end
        if (exp_load_valid) begin
            check_value("load_data_o", load_data_o, exp_data);
            check_value("rf_waddr_o", rf_waddr_o, exp_waddr);
            check_value("instr_id_o", instr_id_o, exp_id);
        end
        exp_evict      = 1'b0;
        exp_load_valid = 1'b0;
        load_i         = 1'b0;
        store_i        = 1'b0;
        fill_i         = 1'b0;
        kill_i         = 1'b0;
    endtask

    task automatic drive_load(input logic [7:0] a, input memop_size_e sz, input logic sx,
                              input logic kill);
        load_i         = 1'b1;
        kill_i         = kill;
        addr_i         = {{(ADDR_SIZE-8){1'b0}}, a};
        size_i         = sz;
        sign_ext_i     = sx;
        rf_waddr_i     = REG_SIZE'(rand_word());
        instr_id_i     = ID_SIZE'(rand_word());
        exp_load_valid = 1'b1;
        exp_data       = expect_load(a, sz, sx);
        exp_waddr      = rf_waddr_i;
        exp_id         = instr_id_i;
    endtask

    task automatic drive_store(input logic [7:0] a, input memop_size_e sz,
                               input logic [31:0] data);
        logic [7:0] idx;
        store_i      = 1'b1;
        addr_i       = {{(ADDR_SIZE-8){1'b0}}, a};
        size_i       = sz;
        store_data_i = data;
        for (int k = 0; k < size_bytes(sz); k++) begin
            idx             = a + 8'(k);
            pend_valid[idx] = 1'b1;
            pend_byte[idx]  = data[k*8 +: 8];
        end
    endtask

    task automatic load_op(input logic [7:0] a, input memop_size_e sz, input logic sx,
                           input logic kill);
        step();
        drive_load(a, sz, sx, kill);
    endtask

    task automatic store_op(input logic [7:0] a, input memop_size_e sz,
                            input logic [31:0] data);
        step();
        drive_store(a, sz, data);
    endtask

    // Load sees the old word, the store lands at the same edge
    task automatic store_load_op(input logic [7:0] a, input logic [31:0] data);
        step();
        drive_load(a, WORD, 1'b0, 1'b0);
        drive_store(a, WORD, data);
    endtask

    task automatic fill_op(input logic [3:0] idx, input logic [127:0] line);
        step();
        fill_i       = 1'b1;
        fill_index_i = idx;
        fill_line_i  = line;
        exp_evict    = dirty_m[idx];
        for (int o = 0; o < 16; o++) begin
            exp_line[o*8 +: 8] = cmem[{idx, 4'(o)}];
            cmem[{idx, 4'(o)}] = line[o*8 +: 8];
        end
        dirty_m[idx] = 1'b0;
    endtask

    task automatic wait_empty();
        int n;
        n = 0;
        step();
        while (!sb_empty_o && n < DRAIN_LIMIT) begin
            step();
            n++;
        end
        if (!sb_empty_o) begin
            errors++;
            $display("Store buffer did not drain within %0d cycles", DRAIN_LIMIT);
        end
        for (int a = 0; a < 256; a++) begin
            if (pend_valid[a]) begin
                cmem[a]         = pend_byte[a];
                dirty_m[a >> 4] = 1'b1;
                pend_valid[a]   = 1'b0;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_value("rf_we_o after reset", rf_we_o, 1'b0);
        check_value("evict_valid_o after reset", evict_valid_o, 1'b0);
        check_value("sb_full_o after reset", sb_full_o, 1'b0);
        check_value("sb_empty_o after reset", sb_empty_o, 1'b1);
        report_test("reset", e0);
    endtask

    task automatic test_fill_load();
        int         e0;
        logic [7:0] base;
        e0 = errors;
        for (int i = 0; i < NUM_LINES; i++) begin
            fill_op(INDEX_SIZE'(i), {rand_word(), rand_word(), rand_word(), rand_word()});
        end
        for (int n = 0; n < 8; n++) begin
            base = align_addr(8'(rand_word()), WORD);
            for (int o = 0; o < 4; o++) begin
                load_op(base + 8'(o), BYTE, 1'b0, 1'b0);
                load_op(base + 8'(o), BYTE, 1'b1, 1'b0);
                if (o % 2 == 0) begin
                    load_op(base + 8'(o), HALF, 1'b0, 1'b0);
                    load_op(base + 8'(o), HALF, 1'b1, 1'b0);
                end
                if (o == 0) begin
                    load_op(base, WORD, 1'b0, 1'b0);
                    load_op(base, WORD, 1'b1, 1'b0);
                end
            end
        end
        step();
        report_test("fill_load", e0);
    endtask

    task automatic test_forwarding();
        int          e0;
        logic [7:0]  a;
        memop_size_e sz;
        e0 = errors;
        for (int n = 0; n < 8; n++) begin
            sz = (n % 2 == 0) ? BYTE : HALF;
            a  = align_addr(8'(rand_word()), sz);
            store_op(a, sz, rand_word());
            // Back-to-back loads hold off the drain
            for (int k = 0; k < 3; k++) begin
                load_op(align_addr(a, WORD), WORD, 1'b0, 1'b0);
            end
        end
        wait_empty();
        report_test("forwarding", e0);
    endtask

    task automatic test_drain_evict();
        int          e0;
        logic [3:0]  lidx;
        logic [7:0]  addrs [6];
        memop_size_e sz;
        e0   = errors;
        lidx = 4'(rand_word());
        for (int n = 0; n < 6; n++) begin
            sz       = memop_size_e'(n % 3);
            addrs[n] = align_addr({lidx, 4'(rand_word())}, sz);
            store_op(addrs[n], sz, rand_word());
        end
        wait_empty();
        for (int n = 0; n < 6; n++) begin
            load_op(align_addr(addrs[n], WORD), WORD, 1'b0, 1'b0);
        end
        step();
        fill_op(lidx, {rand_word(), rand_word(), rand_word(), rand_word()});
        step();
        check_value("evict_valid_o on dirty fill", evict_valid_o, 1'b1);
        step();
        check_value("evict_valid_o one cycle later", evict_valid_o, 1'b0);
        fill_op(lidx, {rand_word(), rand_word(), rand_word(), rand_word()});
        step();
        check_value("evict_valid_o on clean fill", evict_valid_o, 1'b0);
        report_test("drain_evict", e0);
    endtask

    task automatic test_kill();
        int         e0;
        logic [7:0] a;
        e0 = errors;
        a  = align_addr(8'(rand_word()), WORD);
        load_op(a, WORD, 1'b0, 1'b1);
        load_op(a, WORD, 1'b0, 1'b0);
        step();
        check_value("rf_we_o after unkilled load", rf_we_o, 1'b1);
        report_test("kill", e0);
    endtask

    task automatic test_full();
        int         e0;
        logic [7:0] base;
        e0   = errors;
        base = 8'(rand_word());
        wait_empty();
        for (int i = 0; i < SB_DEPTH; i++) begin
            store_load_op({base[7:4], 2'(i), 2'b00}, rand_word());
        end
        for (int i = 0; i < SB_DEPTH; i++) begin
            load_op({base[7:4], 2'(i), 2'b00}, WORD, 1'b0, 1'b0);
            if (i == 0) begin
                check_value("sb_full_o after fourth store", sb_full_o, 1'b1);
            end
        end
        wait_empty();
        report_test("full", e0);
    endtask

    initial begin
        clk_i          = 1'b0;
        reset_i        = 1'b1;
        kill_i         = 1'b0;
        load_i         = 1'b0;
        store_i        = 1'b0;
        addr_i         = '0;
        size_i         = WORD;
        sign_ext_i     = 1'b0;
        store_data_i   = '0;
        rf_waddr_i     = '0;
        instr_id_i     = '0;
        fill_i         = 1'b0;
        fill_index_i   = '0;
        fill_line_i    = '0;
        exp_load_valid = 1'b0;
        exp_evict      = 1'b0;
        exp_data       = '0;
        exp_waddr      = '0;
        exp_id         = '0;
        exp_line       = '0;
        rng_state      = 32'h6168_9a4d;
        errors         = 0;
        checks         = 0;
        for (int a = 0; a < 256; a++) begin
            cmem[a]       = 8'h00;
            pend_valid[a] = 1'b0;
            pend_byte[a]  = 8'h00;
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            dirty_m[i] = 1'b0;
        end

        repeat (10) @(posedge clk_i);
        #DRIVE_DELAY;
        reset_i = 1'b0;

        test_reset();
        test_fill_load();
        test_forwarding();
        test_drain_evict();
        test_kill();
        test_full();

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
